//--- Makefile
SOURCES := $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)

all: run

obj_dir/Vtb_rv_core: filelist.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_rv_core -f filelist.f

run: obj_dir/Vtb_rv_core
	./obj_dir/Vtb_rv_core > sim.log 2>&1; cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- filelist.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/ex_mem_reg.sv
rtl/rv_result.sv
rtl/rv_core_top.sv
tests/tb_clkgen.sv
tests/tb_checker.sv
tests/tb_rv_core.sv

//--- rtl/ex_mem_reg.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module ex_mem_reg
    import rv_pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid,
    input  logic             ena,
    input  logic [`XLEN-1:0] ex_pc,
    input  logic [31:0]      ex_inst,
    input  logic [`XLEN-1:0] ex_alu_result,
    input  res_sel_e         ex_sel_rfres,
    input  logic             ex_mem_wen,
    input  logic             ex_mem_ena,
    input  logic [3:0]       ex_mem_mask,
    input  logic [`XLEN-1:0] ex_rf_rdata2,
    input  memdata_sel_e     ex_sel_memdata,
    input  logic             ex_rf_we,
    input  logic [4:0]       ex_rf_waddr,
    input  logic             ex_ebreak,
    input  logic             ex_load,
    output logic             mem_valid,
    output logic [`XLEN-1:0] mem_pc,
    output logic [31:0]      mem_inst,
    output logic [`XLEN-1:0] mem_alu_result,
    output res_sel_e         mem_sel_rfres,
    output logic             mem_mem_wen,
    output logic             mem_mem_ena,
    output logic [3:0]       mem_mem_mask,
    output logic [`XLEN-1:0] mem_rf_rdata2,
    output memdata_sel_e     mem_sel_memdata,
    output logic             mem_rf_we,
    output logic [4:0]       mem_rf_waddr,
    output logic             mem_ebreak,
    output logic             mem_load
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid       <= 1'b0;
            mem_pc          <= `RESET_PC;
            mem_inst        <= '0;
            mem_alu_result  <= '0;
            mem_sel_rfres   <= RES_ALU;
            mem_mem_wen     <= 1'b0;
            mem_mem_ena     <= 1'b0;
            mem_mem_mask    <= 4'h0;
            mem_rf_rdata2   <= '0;
            mem_sel_memdata <= MD_NONE;
            mem_rf_we       <= 1'b0;
            mem_rf_waddr    <= 5'd0;
            mem_ebreak      <= 1'b0;
            mem_load        <= 1'b0;
        end else if (ena) begin
            // A bubble loads the same values as reset.
            mem_valid       <= valid;
            mem_pc          <= valid ? ex_pc : `RESET_PC;
            mem_inst        <= valid ? ex_inst : '0;
            mem_alu_result  <= valid ? ex_alu_result : '0;
            mem_sel_rfres   <= valid ? ex_sel_rfres : RES_ALU;
            mem_mem_wen     <= valid && ex_mem_wen;
            mem_mem_ena     <= valid && ex_mem_ena;
            mem_mem_mask    <= valid ? ex_mem_mask : 4'h0;
            mem_rf_rdata2   <= valid ? ex_rf_rdata2 : '0;
            mem_sel_memdata <= valid ? ex_sel_memdata : MD_NONE;
            mem_rf_we       <= valid && ex_rf_we;
            mem_rf_waddr    <= valid ? ex_rf_waddr : 5'd0;
            mem_ebreak      <= valid && ex_ebreak;
            mem_load        <= valid && ex_load;
        end
    end

endmodule

//--- rtl/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core_top
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             inst_valid,
    input  logic [31:0]      inst,
    input  logic [`XLEN-1:0] inst_pc,
    input  logic             hold,
    output logic             wb_valid,
    output logic [`XLEN-1:0] wb_pc,
    output logic             wb_we,
    output logic [4:0]       wb_rd,
    output logic [`XLEN-1:0] wb_data,
    output logic             halted
);

    logic             ena;
    logic [4:0]       raddr1;
    logic [4:0]       raddr2;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;

    logic             id_valid;
    logic [`XLEN-1:0] id_pc;
    logic [31:0]      id_inst;
    logic [`XLEN-1:0] id_op_a;
    logic [`XLEN-1:0] id_op_b;
    logic [`XLEN-1:0] id_store_data;
    alu_op_e          id_alu_op;
    res_sel_e         id_sel_res;
    memdata_sel_e     id_sel_memdata;
    logic             id_mem_wen;
    logic             id_mem_ena;
    logic [3:0]       id_mem_mask;
    logic             id_rf_we;
    logic [4:0]       id_rd;
    logic             id_ebreak;
    logic             id_load;

    logic             ex_valid;
    logic [`XLEN-1:0] ex_alu_result;

    logic             mem_valid;
    logic [`XLEN-1:0] mem_pc;
    logic [`XLEN-1:0] mem_alu_result;
    res_sel_e         mem_sel_rfres;
    logic             mem_mem_wen;
    logic             mem_mem_ena;
    logic [3:0]       mem_mem_mask;
    logic [`XLEN-1:0] mem_rf_rdata2;
    memdata_sel_e     mem_sel_memdata;
    logic             mem_rf_we;
    logic [4:0]       mem_rf_waddr;
    logic             mem_ebreak;
    logic             mem_load;

    // Hold freezes every stage register at once.
    assign ena = ~hold;

    rv_regfile u_regfile (
        .we    (wb_we),
        .waddr (wb_rd),
        .wdata (wb_data),
        .*
    );

    rv_decode u_decode (.*);

    rv_execute u_execute (.*);

    ex_mem_reg u_ex_mem_reg (
        .valid          (ex_valid),
        .ex_pc          (id_pc),
        .ex_inst        (id_inst),
        .ex_alu_result  (ex_alu_result),
        .ex_sel_rfres   (id_sel_res),
        .ex_mem_wen     (id_mem_wen),
        .ex_mem_ena     (id_mem_ena),
        .ex_mem_mask    (id_mem_mask),
        .ex_rf_rdata2   (id_store_data),
        .ex_sel_memdata (id_sel_memdata),
        .ex_rf_we       (id_rf_we),
        .ex_rf_waddr    (id_rd),
        .ex_ebreak      (id_ebreak),
        .ex_load        (id_load),
        .mem_inst       (),
        .*
    );

    rv_result u_result (.*);

endmodule

//--- rtl/rv_decode.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_decode
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             inst_valid,
    input  logic [31:0]      inst,
    input  logic [`XLEN-1:0] inst_pc,
    input  logic             hold,
    input  logic             halted,
    output logic [4:0]       raddr1,
    output logic [4:0]       raddr2,
    input  logic [`XLEN-1:0] rdata1,
    input  logic [`XLEN-1:0] rdata2,
    output logic             id_valid,
    output logic [`XLEN-1:0] id_pc,
    output logic [31:0]      id_inst,
    output logic [`XLEN-1:0] id_op_a,
    output logic [`XLEN-1:0] id_op_b,
    output logic [`XLEN-1:0] id_store_data,
    output alu_op_e          id_alu_op,
    output res_sel_e         id_sel_res,
    output memdata_sel_e     id_sel_memdata,
    output logic             id_mem_wen,
    output logic             id_mem_ena,
    output logic [3:0]       id_mem_mask,
    output logic             id_rf_we,
    output logic [4:0]       id_rd,
    output logic             id_ebreak,
    output logic             id_load
);

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic             supported;
    logic             take;
    logic [`XLEN-1:0] op_b;
    alu_op_e          alu_op;
    res_sel_e         sel_res;
    memdata_sel_e     sel_memdata;
    logic             mem_wen;
    logic             mem_ena;
    logic             rf_we;
    logic             ebreak;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign raddr1 = inst[19:15];
    assign raddr2 = inst[24:20];
    assign imm_i  = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s  = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};

    always_comb begin
        supported   = 1'b0;
        op_b        = rdata2;
        alu_op      = ALU_ADD;
        sel_res     = RES_ALU;
        sel_memdata = MD_NONE;
        mem_wen     = 1'b0;
        rf_we       = 1'b0;
        ebreak      = 1'b0;
        case (opcode)
            OPC_OP: begin
                rf_we     = 1'b1;
                supported = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: alu_op = ALU_ADD;
                    {F7_SUB, F3_ADD_SUB}:  alu_op = ALU_SUB;
                    {F7_BASE, F3_XOR}:     alu_op = ALU_XOR;
                    {F7_BASE, F3_OR}:      alu_op = ALU_OR;
                    {F7_BASE, F3_AND}:     alu_op = ALU_AND;
                    default:               supported = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                op_b      = imm_i;
                rf_we     = 1'b1;
                supported = (funct3 == F3_ADD_SUB);
            end
            OPC_LOAD: begin
                op_b        = imm_i;
                rf_we       = 1'b1;
                sel_res     = RES_MEM;
                sel_memdata = MD_LOAD_DW;
                supported   = (funct3 == F3_DW);
            end
            OPC_STORE: begin
                op_b        = imm_s;
                sel_memdata = MD_STORE_DW;
                mem_wen     = 1'b1;
                supported   = (funct3 == F3_DW);
            end
            OPC_SYSTEM: begin
                ebreak    = 1'b1;
                supported = (inst[31:7] == EBREAK_FIELDS);
            end
            default: supported = 1'b0;
        endcase
    end

    assign mem_ena = (sel_memdata != MD_NONE);

    // Anything not taken, including unsupported encodings, enters as a bubble.
    assign take = inst_valid && !halted && supported;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid       <= 1'b0;
            id_pc          <= `RESET_PC;
            id_inst        <= '0;
            id_op_a        <= '0;
            id_op_b        <= '0;
            id_store_data  <= '0;
            id_alu_op      <= ALU_ADD;
            id_sel_res     <= RES_ALU;
            id_sel_memdata <= MD_NONE;
            id_mem_wen     <= 1'b0;
            id_mem_ena     <= 1'b0;
            id_mem_mask    <= 4'h0;
            id_rf_we       <= 1'b0;
            id_rd          <= 5'd0;
            id_ebreak      <= 1'b0;
            id_load        <= 1'b0;
        end else if (!hold) begin
            id_valid       <= take;
            id_pc          <= take ? inst_pc : `RESET_PC;
            id_inst        <= take ? inst : '0;
            id_op_a        <= take ? rdata1 : '0;
            id_op_b        <= take ? op_b : '0;
            id_store_data  <= take ? rdata2 : '0;
            id_alu_op      <= take ? alu_op : ALU_ADD;
            id_sel_res     <= take ? sel_res : RES_ALU;
            id_sel_memdata <= take ? sel_memdata : MD_NONE;
            id_mem_wen     <= take && mem_wen;
            id_mem_ena     <= take && mem_ena;
            // Only doubleword access exists, so all four lanes are enabled.
            id_mem_mask    <= (take && mem_ena) ? 4'hf : 4'h0;
            id_rf_we       <= take && rf_we;
            id_rd          <= take ? inst[11:7] : 5'd0;
            id_ebreak      <= take && ebreak;
            id_load        <= take && (sel_memdata == MD_LOAD_DW);
        end
    end

endmodule

//--- rtl/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data path and PC width.
`define XLEN 64

// Pipeline registers hold this PC after reset or a bubble.
`define RESET_PC 64'h8000_0000

// Data memory depth in doublewords.
`define DMEM_WORDS 256

`endif

//--- rtl/rv_execute.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_execute
    import rv_isa_pkg::*;
(
    input  logic             id_valid,
    input  logic [`XLEN-1:0] id_op_a,
    input  logic [`XLEN-1:0] id_op_b,
    input  alu_op_e          id_alu_op,
    output logic             ex_valid,
    output logic [`XLEN-1:0] ex_alu_result
);

    logic             is_sub;
    logic [`XLEN-1:0] addend;
    logic [`XLEN-1:0] sum;

    // One adder serves ADD, SUB and the load/store address.
    assign is_sub = (id_alu_op == ALU_SUB);
    assign addend = is_sub ? ~id_op_b : id_op_b;
    assign sum    = id_op_a + addend + {{(`XLEN-1){1'b0}}, is_sub};

    always_comb begin
        case (id_alu_op)
            ALU_AND: ex_alu_result = id_op_a & id_op_b;
            ALU_OR:  ex_alu_result = id_op_a | id_op_b;
            ALU_XOR: ex_alu_result = id_op_a ^ id_op_b;
            default: ex_alu_result = sum;
        endcase
    end

    assign ex_valid = id_valid;

endmodule

//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_DW      = 3'b011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // Bits 31:7 of EBREAK hold an immediate of 1 and zero rs1, funct3 and rd fields.
    localparam logic [24:0] EBREAK_FIELDS = 25'h0002000;

endpackage

//--- rtl/rv_pipe_pkg.sv
package rv_pipe_pkg;

    // Source of the write-back value.
    typedef enum logic [2:0] {
        RES_ALU = 3'd0,
        RES_MEM = 3'd1
    } res_sel_e;

    // Kind of data memory access.
    typedef enum logic [1:0] {
        MD_NONE     = 2'd0,
        MD_LOAD_DW  = 2'd1,
        MD_STORE_DW = 2'd2
    } memdata_sel_e;

endpackage

//--- rtl/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [4:0]       raddr1,
    input  logic [4:0]       raddr2,
    output logic [`XLEN-1:0] rdata1,
    output logic [`XLEN-1:0] rdata2,
    input  logic             we,
    input  logic [4:0]       waddr,
    input  logic [`XLEN-1:0] wdata
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // A write in progress is passed straight to a reader of the same register.
    assign rdata1 = (raddr1 == 5'd0) ? '0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

//--- rtl/rv_result.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_result
    import rv_pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ena,
    input  logic             mem_valid,
    input  logic [`XLEN-1:0] mem_pc,
    input  logic [`XLEN-1:0] mem_alu_result,
    input  res_sel_e         mem_sel_rfres,
    input  logic             mem_mem_wen,
    input  logic             mem_mem_ena,
    input  logic [3:0]       mem_mem_mask,
    input  logic [`XLEN-1:0] mem_rf_rdata2,
    input  memdata_sel_e     mem_sel_memdata,
    input  logic             mem_rf_we,
    input  logic [4:0]       mem_rf_waddr,
    input  logic             mem_ebreak,
    input  logic             mem_load,
    output logic             wb_valid,
    output logic [`XLEN-1:0] wb_pc,
    output logic             wb_we,
    output logic [4:0]       wb_rd,
    output logic [`XLEN-1:0] wb_data,
    output logic             halted
);

    localparam int AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] dmem [`DMEM_WORDS];
    logic [AW-1:0]    idx;
    logic [`XLEN-1:0] lane_mask;
    logic [`XLEN-1:0] load_data;
    logic [`XLEN-1:0] res_data;
    logic             store_en;

    assign idx = mem_alu_result[AW+2:3];

    // Each mask bit covers one 16-bit lane of the doubleword.
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_mask[i*16 +: 16] = {16{mem_mem_mask[i]}};
        end
    end

    assign store_en = ena && mem_mem_ena && mem_mem_wen && (mem_sel_memdata == MD_STORE_DW);

    always_ff @(posedge clk) begin
        if (store_en) begin
            dmem[idx] <= (dmem[idx] & ~lane_mask) | (mem_rf_rdata2 & lane_mask);
        end
    end

    assign load_data = (mem_load && mem_mem_ena && mem_sel_memdata == MD_LOAD_DW) ?
                       dmem[idx] : '0;
    assign res_data  = (mem_sel_rfres == RES_MEM) ? load_data : mem_alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_pc    <= `RESET_PC;
            wb_we    <= 1'b0;
            wb_rd    <= 5'd0;
            wb_data  <= '0;
            halted   <= 1'b0;
        end else if (ena) begin
            wb_valid <= mem_valid;
            wb_pc    <= mem_pc;
            wb_we    <= mem_rf_we;
            wb_rd    <= mem_rf_waddr;
            wb_data  <= res_data;
            // Halt is sticky until the next reset.
            if (mem_valid && mem_ebreak) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

//--- tests/tb_checker.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_checker (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             hold,
    input  logic             wb_valid,
    input  logic [`XLEN-1:0] wb_pc,
    input  logic             wb_we,
    input  logic [4:0]       wb_rd,
    input  logic [`XLEN-1:0] wb_data,
    input  logic             halted,
    input  logic             push,
    input  logic [`XLEN-1:0] exp_pc,
    input  logic             exp_we,
    input  logic [4:0]       exp_rd,
    input  logic [`XLEN-1:0] exp_data,
    input  logic             exp_halt,
    output int               mismatch_count,
    output int               unexpected_count,
    output int               pending
);

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic             we;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
        logic             halt;
    } wb_entry_t;

    wb_entry_t expected_q [$];
    wb_entry_t head;
    wb_entry_t incoming;
    logic      halt_seen = 1'b0;
    int        mismatches = 0;
    int        unexpected = 0;
    int        queued = 0;

    assign mismatch_count   = mismatches;
    assign unexpected_count = unexpected;
    assign pending          = queued;

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("Mismatch at %0t: %s is %h, expected %h (pc %h)",
                 $time, what, got, want, wb_pc);
        mismatches++;
    endtask

    task automatic compare_entry(input wb_entry_t e);
        if (wb_pc !== e.pc) begin
            report_mismatch("wb_pc", wb_pc, e.pc);
        end
        if (wb_we !== e.we) begin
            report_mismatch("wb_we", 64'(wb_we), 64'(e.we));
        end
        // Destination and data only mean something when the register file is written.
        if (e.we) begin
            if (wb_rd !== e.rd) begin
                report_mismatch("wb_rd", 64'(wb_rd), 64'(e.rd));
            end
            if (wb_data !== e.data) begin
                report_mismatch("wb_data", wb_data, e.data);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n === 1'b1) begin
            // EBREAK sets halted at the same edge that presents its write-back.
            if (wb_valid === 1'b1 && expected_q.size() > 0 && expected_q[0].halt) begin
                halt_seen = 1'b1;
            end
            if (halted !== halt_seen) begin
                report_mismatch("halted", 64'(halted), 64'(halt_seen));
            end
            if (wb_we === 1'b1 && wb_valid !== 1'b1) begin
                report_mismatch("wb_we without wb_valid", 64'(wb_we), 64'd0);
            end
            if (wb_valid !== 1'b0 && hold === 1'b0) begin
                if (expected_q.size() == 0) begin
                    $display("Unexpected write-back at %0t for pc %h with nothing pending",
                             $time, wb_pc);
                    unexpected++;
                end else begin
                    head = expected_q.pop_front();
                    compare_entry(head);
                end
            end
            if (push) begin
                incoming.pc   = exp_pc;
                incoming.we   = exp_we;
                incoming.rd   = exp_rd;
                incoming.data = exp_data;
                incoming.halt = exp_halt;
                expected_q.push_back(incoming);
            end
            queued = expected_q.size();
        end
    end

endmodule

//--- tests/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset is released just after the fifth rising edge.
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- tests/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_rv_core;

    localparam int MAX_ROWS = 128;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    // {funct7, funct3} of the register-register operations.
    localparam logic [9:0] FN_ADD = 10'b0000000_000;
    localparam logic [9:0] FN_SUB = 10'b0100000_000;
    localparam logic [9:0] FN_XOR = 10'b0000000_100;
    localparam logic [9:0] FN_OR  = 10'b0000000_110;
    localparam logic [9:0] FN_AND = 10'b0000000_111;

    typedef struct packed {
        logic             valid;
        logic [31:0]      inst;
        logic [`XLEN-1:0] pc;
        logic             hold;
        logic             exp_wb;
        logic             exp_we;
        logic [4:0]       exp_rd;
        logic [`XLEN-1:0] exp_data;
        logic             exp_halt;
    } row_t;

    logic             clk;
    logic             rst_n;
    logic             inst_valid;
    logic [31:0]      inst;
    logic [`XLEN-1:0] inst_pc;
    logic             hold;
    logic             wb_valid;
    logic [`XLEN-1:0] wb_pc;
    logic             wb_we;
    logic [4:0]       wb_rd;
    logic [`XLEN-1:0] wb_data;
    logic             halted;

    logic             push;
    logic [`XLEN-1:0] exp_pc;
    logic             exp_we;
    logic [4:0]       exp_rd;
    logic [`XLEN-1:0] exp_data;
    logic             exp_halt;
    int               mismatch_count;
    int               unexpected_count;
    int               pending;
    int               timeout_count;

    row_t             rows [MAX_ROWS];
    int               n_rows;
    int               slot;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] model_regs [32];
    logic [`XLEN-1:0] model_mem [int];
    int               last_write [32];
    integer           seed;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_core_top u_dut (.*);

    tb_checker u_checker (.*);

    function automatic logic [31:0] r_type(input logic [9:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {fn[9:3], rs2, rs1, fn[2:0], rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [`XLEN-1:0] sext12(input logic [11:0] imm);
        return {{(`XLEN-12){imm[11]}}, imm};
    endfunction

    task automatic add_row(input logic valid, input logic [31:0] word, input logic stall,
                           input logic wb, input logic we, input logic [4:0] rd,
                           input logic [`XLEN-1:0] data, input logic halt);
        rows[n_rows].valid    = valid;
        rows[n_rows].inst     = word;
        rows[n_rows].pc       = next_pc;
        rows[n_rows].hold     = stall;
        rows[n_rows].exp_wb   = wb;
        rows[n_rows].exp_we   = we;
        rows[n_rows].exp_rd   = rd;
        rows[n_rows].exp_data = data;
        rows[n_rows].exp_halt = halt;
        if (valid) begin
            next_pc = next_pc + 64'd4;
        end
        // Held rows freeze the pipeline and do not count as issue slots.
        if (!stall) begin
            slot++;
        end
        n_rows++;
    endtask

    task automatic bubbles(input int count);
        repeat (count) add_row(1'b0, 32'h0, 1'b0, 1'b0, 1'b0, 5'd0, '0, 1'b0);
    endtask

    task automatic holds(input int count);
        repeat (count) add_row(1'b0, 32'h0, 1'b1, 1'b0, 1'b0, 5'd0, '0, 1'b0);
    endtask

    // A consumer must issue at least three slots after its producer.
    task automatic wait_for_reg(input logic [4:0] r);
        while (slot < last_write[r] + 3) begin
            bubbles(1);
        end
    endtask

    task automatic record_write(input logic [4:0] rd, input logic [`XLEN-1:0] value);
        if (rd != 5'd0) begin
            model_regs[rd] = value;
            last_write[rd] = slot;
        end
    endtask

    task automatic op_reg(input logic [9:0] fn, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] r;
        wait_for_reg(rs1);
        wait_for_reg(rs2);
        a = model_regs[rs1];
        b = model_regs[rs2];
        case (fn)
            FN_SUB:  r = a - b;
            FN_AND:  r = a & b;
            FN_OR:   r = a | b;
            FN_XOR:  r = a ^ b;
            default: r = a + b;
        endcase
        record_write(rd, r);
        add_row(1'b1, r_type(fn, rd, rs1, rs2), 1'b0, 1'b1, 1'b1, rd, r, 1'b0);
    endtask

    task automatic op_imm(input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        logic [`XLEN-1:0] r;
        wait_for_reg(rs1);
        r = model_regs[rs1] + sext12(imm);
        record_write(rd, r);
        add_row(1'b1, i_type(imm, rs1, 3'b000, rd, OPC_OP_IMM), 1'b0, 1'b1, 1'b1, rd, r,
                1'b0);
    endtask

    task automatic store_dw(input logic [4:0] rs2, input logic [4:0] rs1,
                            input logic [11:0] imm);
        logic [`XLEN-1:0] addr;
        wait_for_reg(rs1);
        wait_for_reg(rs2);
        addr = model_regs[rs1] + sext12(imm);
        model_mem[int'(addr[31:3])] = model_regs[rs2];
        add_row(1'b1, s_type(imm, rs2, rs1), 1'b0, 1'b1, 1'b0, 5'd0, '0, 1'b0);
    endtask

    task automatic load_dw(input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [11:0] imm);
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] r;
        wait_for_reg(rs1);
        addr = model_regs[rs1] + sext12(imm);
        r = model_mem[int'(addr[31:3])];
        record_write(rd, r);
        add_row(1'b1, i_type(imm, rs1, 3'b011, rd, OPC_LOAD), 1'b0, 1'b1, 1'b1, rd, r, 1'b0);
    endtask

    task automatic build_program();
        logic [31:0] rnd;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
            last_write[k] = -10;
        end
        n_rows  = 0;
        slot    = 0;
        next_pc = 64'h0000_0000_8000_0100;

        bubbles(3);
        for (int k = 1; k <= 4; k++) begin
            rnd = $random(seed);
            op_imm(5'(k), 5'd0, rnd[11:0]);
        end
        // The x0 write shows on the port but the register stays zero.
        rnd = $random(seed);
        op_imm(5'd0, 5'd0, rnd[11:0]);
        op_reg(FN_ADD, 5'd5, 5'd1, 5'd2);
        op_reg(FN_SUB, 5'd6, 5'd3, 5'd4);
        op_reg(FN_AND, 5'd7, 5'd1, 5'd3);
        op_reg(FN_OR, 5'd8, 5'd2, 5'd4);
        op_reg(FN_XOR, 5'd9, 5'd5, 5'd6);
        op_reg(FN_ADD, 5'd10, 5'd0, 5'd1);

        op_imm(5'd11, 5'd0, 12'h200);
        store_dw(5'd9, 5'd11, 12'h008);
        load_dw(5'd12, 5'd11, 12'h008);
        store_dw(5'd6, 5'd11, 12'hff8);
        load_dw(5'd13, 5'd11, 12'hff8);
        op_reg(FN_ADD, 5'd14, 5'd12, 5'd13);

        // Stalls while several instructions are in flight.
        rnd = $random(seed);
        op_imm(5'd15, 5'd1, rnd[11:0]);
        holds(2);
        rnd = $random(seed);
        op_imm(5'd16, 5'd2, rnd[11:0]);
        op_reg(FN_XOR, 5'd17, 5'd3, 5'd4);
        holds(1);
        op_reg(FN_SUB, 5'd18, 5'd15, 5'd16);
        load_dw(5'd19, 5'd11, 12'h008);
        holds(3);
        op_reg(FN_OR, 5'd20, 5'd17, 5'd18);
        holds(1);

        add_row(1'b1, 32'h0010_0073, 1'b0, 1'b1, 1'b0, 5'd0, '0, 1'b1);
        // Two slots are still taken before halted reaches decode.
        bubbles(2);
        add_row(1'b1, i_type(12'h055, 5'd0, 3'b000, 5'd21, OPC_OP_IMM), 1'b0, 1'b0, 1'b0,
                5'd0, '0, 1'b0);
        add_row(1'b1, r_type(FN_ADD, 5'd22, 5'd1, 5'd2), 1'b0, 1'b0, 1'b0, 5'd0, '0, 1'b0);
        bubbles(6);
    endtask

    initial begin
        int waited;
        inst_valid    = 1'b0;
        inst          = '0;
        inst_pc       = '0;
        hold          = 1'b0;
        push          = 1'b0;
        exp_pc        = '0;
        exp_we        = 1'b0;
        exp_rd        = 5'd0;
        exp_data      = '0;
        exp_halt      = 1'b0;
        timeout_count = 0;
        seed          = 32'habf4;
        build_program();

        waited = 0;
        while (rst_n !== 1'b1 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was not released within 20 cycles");
            timeout_count++;
        end else begin
            for (int i = 0; i < n_rows; i++) begin
                @(posedge clk);
                #1;
                inst_valid = rows[i].valid;
                inst       = rows[i].inst;
                inst_pc    = rows[i].pc;
                hold       = rows[i].hold;
                push       = rows[i].exp_wb;
                exp_pc     = rows[i].pc;
                exp_we     = rows[i].exp_we;
                exp_rd     = rows[i].exp_rd;
                exp_data   = rows[i].exp_data;
                exp_halt   = rows[i].exp_halt;
            end
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
            hold       = 1'b0;
            push       = 1'b0;

            waited = 0;
            while (pending != 0 && waited < 50) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (pending != 0) begin
                $display("Timed out with %0d expected write-backs still outstanding", pending);
                timeout_count++;
            end
            repeat (4) @(posedge clk);
        end

        $display("Error counts: %0d mismatches, %0d unexpected write-backs, %0d timeouts",
                 mismatch_count, unexpected_count, timeout_count);
        if (mismatch_count == 0 && unexpected_count == 0 && timeout_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
